//--- all.f
hdl/vecCommitPkg.sv
hdl/apbRegPkg.sv
hdl/ringBufferControl.sv
hdl/reorderBuffer.sv
hdl/commitStatusRegs.sv
hdl/vectorCommitTop.sv
dv/tbClock.sv
dv/vectorCommitTb.sv

//--- dv/tbClock.sv
/*
 * Testbench clock and reset, 8 ns period with reset held for 4 cycles
 */

`timescale 1ns/1ps

module tbClock (
	output logic clock,
	output logic reset
);

	initial begin
		clock = 1'b0;
		forever #4 clock = ~clock;
	end

	// Released on a falling edge like the other inputs
	initial begin
		reset = 1'b1;
		repeat (4) @(posedge clock);
		@(negedge clock);
		reset = 1'b0;
	end

endmodule

//--- dv/vectorCommitTb.sv
/*
 * Vector commit testbench: random issue and lane traffic, queue model
 * of the reorder buffer, check task and APB access tasks
 */

`timescale 1ns/1ps

module vectorCommitTb
	import vecCommitPkg::*;
	import apbRegPkg::*;
();

	localparam int numEntry = 16;
	localparam int timeoutCycles = 400;

	logic        clock;
	logic        reset;
	logic        issueValid;
	issueReqT    issueReq;
	logic        issueReady;
	laneDoneVecT laneDone;
	commitT      commit;
	logic        commitReady;
	apbReqT      apbReq;
	apbRspT      apbRsp;

	entryT       model [$];     // Outstanding instructions, head first
	logic        modelEnable;
	issueNoT     nextIssue;
	issueNoT     lastRetired;
	int          retireCount;
	string       testName;

	tbClock clockGen (.clock(clock), .reset(reset));

	vectorCommitTop #(
		.numEntry    (numEntry)
	) UUT (
		.clock       (clock),
		.reset       (reset),
		.issueValid  (issueValid),
		.issueReq    (issueReq),
		.issueReady  (issueReady),
		.laneDone    (laneDone),
		.commit      (commit),
		.commitReady (commitReady),
		.apbReq      (apbReq),
		.apbRsp      (apbRsp)
	);

	////////////////////////////////////////////////////////////////////////////
	// Checking and reference model
	////////////////////////////////////////////////////////////////////////////

	task automatic reportFailure(input string msg);
		$display("%s", msg);
		$display("TEST FAILED");
		$fatal(1);
	endtask

	task automatic checkValue(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (actual !== expected) begin
			reportFailure($sformatf("CHECK FAILED %s expected %h actual %h",
				name, expected, actual));
		end
	endtask

	function automatic logic modelCommitValid();
		if (model.size() == 0) begin
			return 1'b0;
		end
		return modelEnable && (model[0].doneLane == model[0].enLane);
	endfunction

	function automatic logic [31:0] statusModel();
		return (32'(model.size()) << 8) | {30'b0, model.size() == numEntry, model.size() == 0};
	endfunction

	// Apply one rising edge with the inputs that were driven before it
	function automatic void applyEdge();
		logic  fire;
		logic  accept;
		entryT fresh;
		fire = modelCommitValid() && commitReady;
		accept = issueValid && (model.size() < numEntry);
		for (int l = 0; l < numLane; l++) begin
			for (int i = 0; i < model.size(); i++) begin
				if (laneDone[l].valid && laneDone[l].issueNo == model[i].issueNo) begin
					model[i].doneLane = model[i].doneLane |
						(model[i].enLane & (laneMaskT'(1) << laneDone[l].lane));
				end
			end
		end
		if (apbReq.psel && apbReq.penable && apbReq.pwrite && apbReq.paddr == regControl) begin
			modelEnable = apbReq.pwdata[0];
		end
		if (fire) begin
			lastRetired = model[0].issueNo;
			retireCount++;
			void'(model.pop_front());
		end
		if (accept) begin
			fresh.valid = 1'b1;
			fresh.issueNo = issueReq.issueNo;
			fresh.enLane = issueReq.laneMask;
			fresh.doneLane = '0;
			model.push_back(fresh);
			nextIssue++;
		end
	endfunction

	// Advance to the next falling edge and compare the DUT with the model
	task automatic nextCycle();
		@(negedge clock);
		applyEdge();
		checkValue({testName, " commit valid"}, 32'(modelCommitValid()), 32'(commit.valid));
		if (modelCommitValid()) begin
			checkValue({testName, " commit issue number"}, 32'(model[0].issueNo),
				32'(commit.issueNo));
		end
		checkValue({testName, " issue ready"}, 32'(model.size() < numEntry), 32'(issueReady));
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////////////////////////////////////////

	task automatic driveIdle();
		issueValid = 1'b0;
		issueReq = '0;
		laneDone = '0;
		commitReady = 1'b0;
	endtask

	task automatic driveHeadReports();
		for (int l = 0; l < numLane; l++) begin
			laneDone[l] = '0;
			if (model.size() > 0) begin
				laneDone[l].valid = 1'b1;
				laneDone[l].issueNo = model[0].issueNo;
				laneDone[l].lane = laneIdxT'(l);
			end
		end
	endtask

	task automatic driveRandom();
		int span;
		int pick;
		issueValid = ($urandom_range(0, 1) == 1);
		issueReq.issueNo = nextIssue;
		issueReq.laneMask = laneMaskT'($urandom_range(0, 15));
		commitReady = ($urandom_range(0, 3) != 0);
		span = (model.size() < 4) ? model.size() : 4;      // Favor entries near the head
		for (int l = 0; l < numLane; l++) begin
			laneDone[l] = '0;
			laneDone[l].lane = laneIdxT'($urandom_range(0, numLane - 1));
			if (span > 0 && $urandom_range(0, 1) == 1) begin
				pick = $urandom_range(0, span - 1);
				laneDone[l].valid = 1'b1;
				laneDone[l].issueNo = model[pick].issueNo;
			end else if ($urandom_range(0, 7) == 0) begin
				laneDone[l].valid = 1'b1;
				laneDone[l].issueNo = nextIssue + 8'd100;   // Not outstanding
			end
		end
	endtask

	task automatic drainBuffer();
		int waitCnt;
		waitCnt = 0;
		while (model.size() != 0) begin
			if (waitCnt == timeoutCycles) begin
				reportFailure("Timeout: the reorder buffer did not drain");
			end
			waitCnt++;
			driveIdle();
			commitReady = 1'b1;
			driveHeadReports();
			nextCycle();
		end
		driveIdle();
	endtask

	// Setup and access phase, then idle; starts and ends on a falling edge
	task automatic apbAccess(input logic wr, input logic [3:0] addr, input logic [31:0] wdata,
			output logic [31:0] rdata, output logic err);
		int waitCnt;
		apbReq = '0;
		apbReq.psel = 1'b1;
		apbReq.pwrite = wr;
		apbReq.paddr = addr;
		apbReq.pwdata = wdata;
		nextCycle();
		apbReq.penable = 1'b1;
		#1;
		waitCnt = 0;
		while (apbRsp.pready !== 1'b1) begin
			if (waitCnt == 16) begin
				reportFailure("Timeout: the APB slave never raised pready");
			end
			waitCnt++;
			nextCycle();
			#1;
		end
		rdata = apbRsp.prdata;
		err = apbRsp.pslverr;
		nextCycle();
		apbReq = '0;
	endtask

	task automatic readReg(input logic [3:0] addr, input logic [31:0] expected,
			input string what);
		logic [31:0] rdata;
		logic        err;
		apbAccess(1'b0, addr, 32'h0, rdata, err);
		checkValue({testName, " ", what}, expected, rdata);
		checkValue({testName, " ", what, " pslverr"}, 32'h0, 32'(err));
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////////////////////////////////////////

	initial begin
		logic [31:0] rdata;
		logic        err;
		logic [31:0] heldCommit;
		int          waitCnt;
		void'($urandom(36482));
		driveIdle();
		apbReq = '0;
		modelEnable = 1'b0;
		nextIssue = '0;
		lastRetired = '0;
		retireCount = 0;
		testName = "reset";
		waitCnt = 0;
		while (reset !== 1'b0) begin
			if (waitCnt == 20) begin
				reportFailure("Timeout: reset was never released");
			end
			waitCnt++;
			@(posedge clock);
		end
		nextCycle();

		// Nothing retires until software sets commit enable
		testName = "commit enable";
		readReg(regControl, 32'h0, "control");
		readReg(regStatus, 32'h1, "status");
		for (int k = 0; k < 3; k++) begin
			driveIdle();
			issueValid = 1'b1;
			issueReq.issueNo = nextIssue;
			issueReq.laneMask = laneMaskT'($urandom_range(0, 15));
			nextCycle();
		end
		for (int k = 0; k < 3; k++) begin
			driveIdle();
			commitReady = 1'b1;
			for (int l = 0; l < numLane; l++) begin
				laneDone[l].valid = 1'b1;
				laneDone[l].issueNo = model[k].issueNo;
				laneDone[l].lane = laneIdxT'(l);
			end
			nextCycle();
		end
		driveIdle();
		commitReady = 1'b1;
		repeat (4) nextCycle();
		driveIdle();
		readReg(regCommitCount, 32'h0, "commit count while disabled");
		apbAccess(1'b1, regControl, 32'h1, rdata, err);
		checkValue({testName, " control write pslverr"}, 32'h0, 32'(err));
		checkValue({testName, " commit valid after enable"}, 32'h1, 32'(commit.valid));
		readReg(regControl, 32'h1, "control");

		// Out of order lane completion, in order release
		testName = "random order";
		for (int c = 0; c < 400; c++) begin
			driveRandom();
			nextCycle();
		end
		driveIdle();
		testName = "statistics";
		checkValue({testName, " retirements seen"}, 32'h1, 32'(retireCount > 0));
		readReg(regCommitCount, 32'(retireCount), "commit count");
		readReg(regLastCommit, 32'(lastRetired), "last commit");
		drainBuffer();
		readReg(regStatus, 32'h1, "status after drain");

		// Fill against a stalled retire port
		testName = "back pressure";
		waitCnt = 0;
		while (model.size() < numEntry) begin
			if (waitCnt == timeoutCycles) begin
				reportFailure("Timeout: the reorder buffer never filled");
			end
			waitCnt++;
			driveIdle();
			issueValid = 1'b1;
			issueReq.issueNo = nextIssue;
			issueReq.laneMask = laneMaskT'($urandom_range(0, 15));
			driveHeadReports();
			nextCycle();
		end
		checkValue({testName, " issue ready when full"}, 32'h0, 32'(issueReady));
		heldCommit = 32'(commit);
		for (int k = 0; k < 5; k++) begin
			driveIdle();
			issueValid = 1'b1;      // Refused while full
			issueReq.issueNo = nextIssue;
			nextCycle();
			checkValue({testName, " commit held"}, heldCommit, 32'(commit));
		end
		driveIdle();
		readReg(regStatus, 32'h0000_1002, "status when full");
		drainBuffer();
		readReg(regStatus, 32'h1, "status after drain");

		// Bad accesses leave every register alone
		testName = "slave error";
		apbAccess(1'b0, 4'h2, 32'h0, rdata, err);
		checkValue({testName, " unmapped read pslverr"}, 32'h1, 32'(err));
		apbAccess(1'b1, 4'h6, 32'h0, rdata, err);
		checkValue({testName, " unmapped write pslverr"}, 32'h1, 32'(err));
		apbAccess(1'b1, regStatus, 32'h0, rdata, err);
		checkValue({testName, " status write pslverr"}, 32'h1, 32'(err));
		readReg(regControl, 32'h1, "control");
		readReg(regStatus, statusModel(), "status");
		readReg(regCommitCount, 32'(retireCount), "commit count");
		readReg(regLastCommit, 32'(lastRetired), "last commit");

		$display("TEST PASSED");
		$finish;
	end

endmodule

//--- hdl/apbRegPkg.sv
/*
 * APB request and response structs, register offsets
 * and the control word layout
 */

package apbRegPkg;

	typedef struct packed {
		logic        psel;
		logic        penable;
		logic        pwrite;
		logic [3:0]  paddr;     // Byte offset within the block
		logic [31:0] pwdata;
	} apbReqT;

	typedef struct packed {
		logic [31:0] prdata;
		logic        pready;
		logic        pslverr;
	} apbRspT;

	// Register map
	localparam logic [3:0] regControl     = 4'h0;
	localparam logic [3:0] regStatus      = 4'h4;     // Read only
	localparam logic [3:0] regCommitCount = 4'h8;     // Read only
	localparam logic [3:0] regLastCommit  = 4'hC;     // Read only

	// Control word
	typedef struct packed {
		logic [30:0] reserved;
		logic        commitEnable;  // Lets the head entry retire
	} controlT;

endpackage

//--- hdl/commitStatusRegs.sv
/*
 * APB register block: commit enable control, buffer status,
 * commit counter and last committed issue number
 */

`timescale 1ns/1ps

module commitStatusRegs
	import vecCommitPkg::*;
	import apbRegPkg::*;
#(
	parameter int numEntry = 16
)(
	input  logic                      clock,
	input  logic                      reset,
	input  apbReqT                    apbReq,
	output apbRspT                    apbRsp,
	input  logic                      commitFire,
	input  issueNoT                   commitNo,
	input  logic                      full,
	input  logic                      empty,
	input  logic [$clog2(numEntry):0] count,
	output logic                      commitEnable
);

	logic        access;        // Access phase
	logic        mapped;
	logic        badWrite;      // Write to a read-only register
	logic        slvErr;
	logic        ctrlWrite;
	controlT     wrCtrl;
	controlT     rdCtrl;
	logic [31:0] statusWord;
	logic [31:0] commitCount;
	issueNoT     lastCommit;

	//////////////////////////////////////////////////////////////////////////
	// Access decode
	//////////////////////////////////////////////////////////////////////////

	assign access = apbReq.psel & apbReq.penable;

	always_comb begin
		case (apbReq.paddr)
			regControl, regStatus, regCommitCount, regLastCommit: mapped = 1'b1;
			default:                                              mapped = 1'b0;
		endcase
	end

	assign badWrite = apbReq.pwrite & (apbReq.paddr != regControl);
	assign slvErr = access & (~mapped | badWrite);
	assign ctrlWrite = access & apbReq.pwrite & (apbReq.paddr == regControl);

	assign wrCtrl = controlT'(apbReq.pwdata);

	//////////////////////////////////////////////////////////////////////////
	// Registers
	//////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			commitEnable <= 1'b0;
		end else if (ctrlWrite) begin
			commitEnable <= wrCtrl.commitEnable;
		end
	end

	// Retirement statistics
	always_ff @(posedge clock) begin
		if (reset) begin
			commitCount <= '0;
			lastCommit <= '0;
		end else if (commitFire) begin
			commitCount <= commitCount + 1'b1;      // Wraps
			lastCommit <= commitNo;
		end
	end

	//////////////////////////////////////////////////////////////////////////
	// Read path
	//////////////////////////////////////////////////////////////////////////

	always_comb begin
		rdCtrl = '0;
		rdCtrl.commitEnable = commitEnable;   // Reserved bits read as zero
	end

	always_comb begin
		statusWord = '0;
		statusWord[0] = empty;
		statusWord[1] = full;
		statusWord[8 +: $clog2(numEntry) + 1] = count;
	end

	always_comb begin
		case (apbReq.paddr)
			regControl:     apbRsp.prdata = rdCtrl;
			regStatus:      apbRsp.prdata = statusWord;
			regCommitCount: apbRsp.prdata = commitCount;
			regLastCommit:  apbRsp.prdata = {24'b0, lastCommit};
			default:        apbRsp.prdata = '0;
		endcase
	end

	assign apbRsp.pready = 1'b1;      // No wait states
	assign apbRsp.pslverr = slvErr;

endmodule

//--- hdl/reorderBuffer.sv
/*
 * Reorder buffer for vector commit: entry table, lane report matching
 * and in-order release at the head
 */

`timescale 1ns/1ps

module reorderBuffer
	import vecCommitPkg::*;
#(
	parameter int numEntry = 16
)(
	input  logic                      clock,
	input  logic                      reset,
	input  logic                      issueValid,
	input  issueReqT                  issueReq,
	output logic                      issueReady,
	input  laneDoneVecT               laneDone,
	input  logic                      commitEnable,
	input  logic                      commitReady,
	output commitT                    commit,
	output logic                      commitFire,     // Head retires this edge
	output logic [$clog2(numEntry):0] count,
	output logic                      full,
	output logic                      empty
);

	localparam int addrWidth = $clog2(numEntry);

	entryT                 entryTab [numEntry];
	laneMaskT              laneSet  [numEntry];  // Lanes reported this cycle per entry

	logic [addrWidth-1:0]  writeAddr;
	logic [addrWidth-1:0]  readAddr;
	logic                  issueFire;
	entryT                 headEntry;
	logic                  headDone;

	//////////////////////////////////////////////////////////////////////////
	// Handshakes
	//////////////////////////////////////////////////////////////////////////

	assign issueReady = ~full;
	assign issueFire = issueValid & issueReady;

	assign headEntry = entryTab[readAddr];
	assign headDone = (headEntry.doneLane == headEntry.enLane);  // Empty mask is done at once

	// Commit only looks at registered entry state
	assign commit.valid = headEntry.valid & headDone & commitEnable;
	assign commit.issueNo = headEntry.issueNo;
	assign commitFire = commit.valid & commitReady;

	//////////////////////////////////////////////////////////////////////////
	// Lane report matching
	//////////////////////////////////////////////////////////////////////////

	// Every valid report is compared against every valid entry
	always_comb begin
		for (int e = 0; e < numEntry; e++) begin
			laneSet[e] = '0;
			for (int l = 0; l < numLane; l++) begin
				if (laneDone[l].valid && entryTab[e].valid &&
						laneDone[l].issueNo == entryTab[e].issueNo) begin
					laneSet[e][laneDone[l].lane] = 1'b1;
				end
			end
			laneSet[e] = laneSet[e] & entryTab[e].enLane;   // Drop disabled lanes
		end
	end

	//////////////////////////////////////////////////////////////////////////
	// Entry table
	//////////////////////////////////////////////////////////////////////////

	// Later assignments win, so retire clears over a merge on the head
	always_ff @(posedge clock) begin
		if (reset) begin
			for (int e = 0; e < numEntry; e++) begin
				entryTab[e].valid <= 1'b0;
			end
		end else begin
			for (int e = 0; e < numEntry; e++) begin
				entryTab[e].doneLane <= entryTab[e].doneLane | laneSet[e];
			end

			if (commitFire) begin
				entryTab[readAddr].valid <= 1'b0;
			end

			// New entry at the tail
			if (issueFire) begin
				entryTab[writeAddr].valid <= 1'b1;
				entryTab[writeAddr].issueNo <= issueReq.issueNo;
				entryTab[writeAddr].enLane <= issueReq.laneMask;
				entryTab[writeAddr].doneLane <= '0;
			end
		end
	end

	//////////////////////////////////////////////////////////////////////////
	// Pointer control
	//////////////////////////////////////////////////////////////////////////

	ringBufferControl #(
		.numEntry  (numEntry)
	) ringCtrl (
		.clock     (clock),
		.reset     (reset),
		.write     (issueFire),
		.read      (commitFire),
		.writeAddr (writeAddr),
		.readAddr  (readAddr),
		.count     (count),
		.full      (full),
		.empty     (empty)
	);

endmodule

//--- hdl/ringBufferControl.sv
/*
 * Circular buffer controller with write and read pointers,
 * occupancy count and full/empty flags
 */

`timescale 1ns/1ps

module ringBufferControl #(
	parameter int numEntry = 16
)(
	input  logic                        clock,
	input  logic                        reset,
	input  logic                        write,      // Push, already qualified by caller
	input  logic                        read,       // Pop, already qualified by caller
	output logic [$clog2(numEntry)-1:0] writeAddr,
	output logic [$clog2(numEntry)-1:0] readAddr,
	output logic [$clog2(numEntry):0]   count,
	output logic                        full,
	output logic                        empty
);

	// Pointers wrap on their own since numEntry is a power of two
	always_ff @(posedge clock) begin
		if (reset) begin
			writeAddr <= '0;
			readAddr <= '0;
		end else begin
			if (write) begin
				writeAddr <= writeAddr + 1'b1;
			end
			if (read) begin
				readAddr <= readAddr + 1'b1;
			end
		end
	end

	// Occupancy moves by write minus read
	always_ff @(posedge clock) begin
		if (reset) begin
			count <= '0;
		end else begin
			case ({write, read})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;        // Both or neither
			endcase
		end
	end

	assign full = (count == numEntry);
	assign empty = (count == '0);

endmodule

//--- hdl/vecCommitPkg.sv
/*
 * Vector-side types for issue, lane completion reports and commit,
 * plus the lane-count constant and the reorder buffer entry layout
 */

package vecCommitPkg;

	//////////////////////////////////////////////////////////////////////////
	// Sizes
	//////////////////////////////////////////////////////////////////////////

	localparam int numLane = 4;                     // Execution lanes
	localparam int laneIdxWidth = $clog2(numLane);

	typedef logic [7:0] issueNoT;                   // Issue number, wraps
	typedef logic [numLane-1:0] laneMaskT;          // One bit per lane
	typedef logic [laneIdxWidth-1:0] laneIdxT;

	//////////////////////////////////////////////////////////////////////////
	// Port payloads
	//////////////////////////////////////////////////////////////////////////

	// Issue side payload
	typedef struct packed {
		issueNoT  issueNo;
		laneMaskT laneMask;     // Lanes that execute this instruction
	} issueReqT;

	// One lane's completion report
	typedef struct packed {
		logic    valid;
		issueNoT issueNo;
		laneIdxT lane;          // Reporting lane
	} laneDoneT;

	typedef laneDoneT [numLane-1:0] laneDoneVecT;

	// Retire side output
	typedef struct packed {
		logic    valid;
		issueNoT issueNo;
	} commitT;

	// Reorder buffer entry
	typedef struct packed {
		logic     valid;
		issueNoT  issueNo;
		laneMaskT enLane;       // Lanes to wait for
		laneMaskT doneLane;     // Lanes already reported
	} entryT;

endpackage

//--- hdl/vectorCommitTop.sv
/*
 * Vector commit stage top: reorder buffer and APB register block
 */

`timescale 1ns/1ps

module vectorCommitTop
	import vecCommitPkg::*;
	import apbRegPkg::*;
#(
	parameter int numEntry = 16
)(
	input  logic        clock,
	input  logic        reset,
	input  logic        issueValid,
	input  issueReqT    issueReq,
	output logic        issueReady,
	input  laneDoneVecT laneDone,
	output commitT      commit,
	input  logic        commitReady,
	input  apbReqT      apbReq,
	output apbRspT      apbRsp
);

	logic                      commitEnable;
	logic                      commitFire;
	logic                      full;
	logic                      empty;
	logic [$clog2(numEntry):0] count;

	reorderBuffer #(
		.numEntry     (numEntry)
	) rob (
		.clock        (clock),
		.reset        (reset),
		.issueValid   (issueValid),
		.issueReq     (issueReq),
		.issueReady   (issueReady),
		.laneDone     (laneDone),
		.commitEnable (commitEnable),
		.commitReady  (commitReady),
		.commit       (commit),
		.commitFire   (commitFire),
		.count        (count),
		.full         (full),
		.empty        (empty)
	);

	// Software view of the buffer
	commitStatusRegs #(
		.numEntry     (numEntry)
	) regs (
		.clock        (clock),
		.reset        (reset),
		.apbReq       (apbReq),
		.apbRsp       (apbRsp),
		.commitFire   (commitFire),
		.commitNo     (commit.issueNo),
		.full         (full),
		.empty        (empty),
		.count        (count),
		.commitEnable (commitEnable)
	);

endmodule

//--- run.sh
#!/bin/sh
# Build the vector commit testbench with Verilator and run it
verilator --binary --timing -Wno-fatal -f all.f --top-module vectorCommitTb -o simv || exit 1
out=$(./obj_dir/simv 2>&1)
echo "$out"
echo "$out" | grep -q "TEST PASSED" && exit 0 || exit 1
